//--- Bender.yml
package:
  name: vga_display

sources:
  - vga_pkg.sv
  - vga_timing.sv
  - display_window.sv
  - pixel_fetch.sv
  - image_rom.sv
  - vga_display_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_vga_display.sv

//--- display_window.sv
`timescale 1ns/1ps

module display_window #(
    parameter int IMG_WIDTH  = 200,
    parameter int IMG_HEIGHT = 200
) (
    input  logic                        vga_clk,
    input  logic                        sys_rst_n,
    input  logic [vga_pkg::H_CNT_W-1:0] h_cnt,
    input  logic [vga_pkg::V_CNT_W-1:0] v_cnt,
    input  logic [1:0]                  display_mode,
    input  logic [1:0]                  zoom_in_level,
    input  logic [1:0]                  zoom_out_level,
    output logic                        in_image,
    output logic [7:0]                  img_x,
    output logic [7:0]                  img_y
);
    import vga_pkg::*;

    // Per-frame settings
    logic [1:0] mode_r;
    logic [1:0] zin_r;
    logic [1:0] zout_r;

    logic [1:0] zin_clamp;
    logic [1:0] zout_clamp;
    logic [1:0] zin_fit;

    logic [H_CNT_W-1:0] copy_w;
    logic [H_CNT_W-1:0] x0;
    logic [H_CNT_W-1:0] x1;
    logic [H_CNT_W-1:0] dx;
    logic [V_CNT_W-1:0] copy_h;
    logic [V_CNT_W-1:0] y0;
    logic [V_CNT_W-1:0] y1;
    logic [V_CNT_W-1:0] dy;
    logic               hit_x0;
    logic               hit_x1;
    logic               hit_y0;
    logic               hit_y1;

    // Region a single copy lives in, per layout
    function automatic logic [H_CNT_W-1:0] region_w(input logic [1:0] mode);
        return (mode == MODE_SIDE) ? H_CNT_W'(H_ACTIVE / 2) : H_CNT_W'(H_ACTIVE);
    endfunction

    function automatic logic [V_CNT_W-1:0] region_h(input logic [1:0] mode);
        return (mode == MODE_STACK) ? V_CNT_W'(V_ACTIVE / 2) : V_CNT_W'(V_ACTIVE);
    endfunction

    // Clamp levels, let zoom out win, then pick the largest zoom in that fits
    always_comb begin
        zin_clamp  = (zoom_in_level == 2'd3) ? 2'd2 : zoom_in_level;
        zout_clamp = (zoom_out_level == 2'd3) ? 2'd2 : zoom_out_level;
        zin_fit    = 2'd0;
        if (zout_clamp == 2'd0) begin
            for (int k = 1; k <= 2; k++) begin
                if (k <= zin_clamp &&
                    (IMG_WIDTH << k) <= region_w(display_mode) &&
                    (IMG_HEIGHT << k) <= region_h(display_mode)) begin
                    zin_fit = 2'(k);
                end
            end
        end
    end

    // Settings are taken only at the first cycle of a frame
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            mode_r <= MODE_SINGLE;
            zin_r  <= 2'd0;
            zout_r <= 2'd0;
        end else if (h_cnt == '0 && v_cnt == '0) begin
            mode_r <= display_mode;
            zin_r  <= zin_fit;
            zout_r <= zout_clamp;
        end
    end

    // Copy placement; second copy sits one region further on
    always_comb begin
        copy_w = H_CNT_W'((IMG_WIDTH >> zout_r) << zin_r);
        copy_h = V_CNT_W'((IMG_HEIGHT >> zout_r) << zin_r);
        x0 = H_CNT_W'(H_ACT_START) + ((region_w(mode_r) - copy_w) >> 1);
        y0 = V_CNT_W'(V_ACT_START) + ((region_h(mode_r) - copy_h) >> 1);
        x1 = (mode_r == MODE_SIDE) ? x0 + H_CNT_W'(H_ACTIVE / 2) : x0;
        y1 = (mode_r == MODE_STACK) ? y0 + V_CNT_W'(V_ACTIVE / 2) : y0;

        hit_x0 = (h_cnt >= x0) && (h_cnt < x0 + copy_w);
        hit_x1 = (h_cnt >= x1) && (h_cnt < x1 + copy_w);
        hit_y0 = (v_cnt >= y0) && (v_cnt < y0 + copy_h);
        hit_y1 = (v_cnt >= y1) && (v_cnt < y1 + copy_h);

        // Mode 3 shows nothing
        in_image = (mode_r != 2'd3) && (hit_x0 || hit_x1) && (hit_y0 || hit_y1);

        dx = hit_x0 ? h_cnt - x0 : h_cnt - x1;
        dy = hit_y0 ? v_cnt - y0 : v_cnt - y1;

        // Subsample on zoom out, repeat on zoom in
        if (zout_r != 2'd0) begin
            img_x = 8'(dx << zout_r);
            img_y = 8'(dy << zout_r);
        end else begin
            img_x = 8'(dx >> zin_r);
            img_y = 8'(dy >> zin_r);
        end
    end

endmodule

//--- image_rom.sv
`timescale 1ns/1ps

module image_rom #(
    parameter int IMG_WIDTH  = 200,
    parameter int IMG_HEIGHT = 200
) (
    input  logic                       vga_clk,
    input  logic [vga_pkg::ADDR_W-1:0] addr,
    output logic [vga_pkg::PIX_W-1:0]  q
);
    import vga_pkg::*;

    localparam int DEPTH = IMG_WIDTH * IMG_HEIGHT;

    logic [PIX_W-1:0] mem [DEPTH];

    // Load the test pattern
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = test_pixel(ADDR_W'(i));
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge vga_clk) begin
        q <= mem[addr];
    end

endmodule

//--- pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch #(
    parameter int IMG_WIDTH = 200
) (
    input  logic                       vga_clk,
    input  logic                       sys_rst_n,
    input  logic                       in_image,
    input  logic [7:0]                 img_x,
    input  logic [7:0]                 img_y,
    input  logic                       hsync_raw,
    input  logic                       vsync_raw,
    input  logic [vga_pkg::PIX_W-1:0]  q,
    output logic [vga_pkg::ADDR_W-1:0] addr,
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic [vga_pkg::PIX_W-1:0]  vga_rgb
);
    import vga_pkg::*;

    // Stage 1 and stage 2 copies of the hit flag and syncs
    logic hit_d1;
    logic hit_d2;
    logic hs_d1;
    logic hs_d2;
    logic vs_d1;
    logic vs_d2;

    // Stage 1, row-major address; held outside the image
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            addr <= '0;
        end else if (in_image) begin
            addr <= ADDR_W'(img_y * IMG_WIDTH + img_x);
        end
    end

    // Delay line, matched to the ROM read
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hit_d1 <= 1'b0;
            hit_d2 <= 1'b0;
            hs_d1  <= 1'b1;
            hs_d2  <= 1'b1;
            vs_d1  <= 1'b1;
            vs_d2  <= 1'b1;
        end else begin
            hit_d1 <= in_image;
            hit_d2 <= hit_d1;
            hs_d1  <= hsync_raw;
            hs_d2  <= hs_d1;
            vs_d1  <= vsync_raw;
            vs_d2  <= vs_d1;
        end
    end

    // Stage 3, output registers
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vga_rgb   <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            vga_rgb   <= hit_d2 ? q : '0;
            vga_hsync <= hs_d2;
            vga_vsync <= vs_d2;
        end
    end

endmodule

//--- project.f
vga_pkg.sv
vga_timing.sv
display_window.sv
pixel_fetch.sv
image_rom.sv
vga_display_top.sv
tb_clk_gen.sv
tb_vga_display.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic vga_clk,
    output logic sys_rst_n
);

    initial begin
        vga_clk = 1'b0;
        forever #(PERIOD_NS / 2) vga_clk = ~vga_clk;
    end

    // Reset goes low just after time zero and lifts on a falling edge
    initial begin
        sys_rst_n = 1'b1;
        #1 sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge vga_clk);
        @(negedge vga_clk);
        sys_rst_n = 1'b1;
    end

endmodule

//--- tb_vga_display.sv
`timescale 1ns/1ps

module tb_vga_display;
    import vga_pkg::*;

    localparam int IMG_W     = 200;
    localparam int IMG_H     = 200;
    localparam int NUM_TESTS = 9;
    // This test is set in the middle of the frame before it
    localparam int MID_TEST  = 7;
    localparam int MID_LINE  = 300;
    localparam int PICKS     = 2000;
    localparam int FRAME_CYC = V_TOTAL * H_TOTAL;
    localparam int LIMIT     = (NUM_TESTS + 1) * FRAME_CYC + 1000;
    localparam logic [1:0] MODE_BLANK = 2'd3;

    logic             vga_clk;
    logic             sys_rst_n;
    logic [1:0]       display_mode;
    logic [1:0]       zoom_in_level;
    logic [1:0]       zoom_out_level;
    logic             vga_hsync;
    logic             vga_vsync;
    logic [PIX_W-1:0] vga_rgb;

    string      t_name [NUM_TESTS];
    logic [1:0] t_mode [NUM_TESTS];
    logic [1:0] t_zin  [NUM_TESTS];
    logic [1:0] t_zout [NUM_TESTS];

    // Screen position rebuilt from the output syncs
    int   col;
    int   row;
    int   frame;
    bit   line_seen;
    logic prev_hs;
    logic prev_vs;
    int   hs_low;
    int   vs_low;
    int   frame_cyc;
    int   cycles;
    int   seed;
    bit   pick [int];
    int   log_x [$];
    int   log_y [$];

    tb_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (8)
    ) u_clk (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n)
    );

    vga_display_top #(
        .IMG_WIDTH  (IMG_W),
        .IMG_HEIGHT (IMG_H)
    ) uut (
        .vga_clk        (vga_clk),
        .sys_rst_n      (sys_rst_n),
        .display_mode   (display_mode),
        .zoom_in_level  (zoom_in_level),
        .zoom_out_level (zoom_out_level),
        .vga_hsync      (vga_hsync),
        .vga_vsync      (vga_vsync),
        .vga_rgb        (vga_rgb)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "first error seen");
    endtask

    task automatic set_test(input int k, input string name, input int mode,
                            input int zin, input int zout);
        t_name[k] = name;
        t_mode[k] = 2'(mode);
        t_zin[k]  = 2'(zin);
        t_zout[k] = 2'(zout);
    endtask

    task automatic apply_settings(input int k);
        display_mode   = t_mode[k];
        zoom_in_level  = t_zin[k];
        zoom_out_level = t_zout[k];
    endtask

    // Visible positions whose image coordinates get logged this frame
    task automatic pick_positions();
        logic [31:0] rnd;
        pick.delete();
        while (pick.size() < PICKS) begin
            rnd = $random(seed);
            pick[{1'b0, rnd[30:0]} % (H_ACTIVE * V_ACTIVE)] = 1'b1;
        end
    endtask

    // Screen position to source coordinates, from the layout and zoom rules
    function automatic bit map_position(input int c, input int r, input int mode,
                                        input int zin, input int zout,
                                        output int sx, output int sy);
        int rw;
        int rh;
        int zi;
        int zo;
        int cw;
        int ch;
        int dx;
        int dy;
        sx = 0;
        sy = 0;
        if (mode == MODE_BLANK) return 1'b0;
        rw = (mode == MODE_SIDE) ? H_ACTIVE / 2 : H_ACTIVE;
        rh = (mode == MODE_STACK) ? V_ACTIVE / 2 : V_ACTIVE;
        zo = (zout > 2) ? 2 : zout;
        zi = (zo > 0) ? 0 : ((zin > 2) ? 2 : zin);
        while (zi > 0 && ((IMG_W << zi) > rw || (IMG_H << zi) > rh)) begin
            zi--;
        end
        cw = (IMG_W >> zo) << zi;
        ch = (IMG_H >> zo) << zi;
        dx = c - H_ACT_START;
        dy = r - V_ACT_START;
        if (dx < 0 || dx >= H_ACTIVE || dy < 0 || dy >= V_ACTIVE) return 1'b0;
        // Offset from the corner of the copy in whichever region holds us
        dx = dx % rw - (rw - cw) / 2;
        dy = dy % rh - (rh - ch) / 2;
        if (dx < 0 || dx >= cw || dy < 0 || dy >= ch) return 1'b0;
        sx = (zo > 0) ? dx << zo : dx >> zi;
        sy = (zo > 0) ? dy << zo : dy >> zi;
        return 1'b1;
    endfunction

    function automatic logic [PIX_W-1:0] expected_pixel(input int c, input int r, input int k);
        int sx;
        int sy;
        if (!map_position(c, r, t_mode[k], t_zin[k], t_zout[k], sx, sy)) return '0;
        return test_pixel(ADDR_W'(sy * IMG_W + sx));
    endfunction

    initial begin
        set_test(0, "single_nozoom", 0, 0, 0);
        set_test(1, "side_nozoom", 1, 0, 0);
        set_test(2, "stack_nozoom", 2, 0, 0);
        set_test(3, "single_zoom_in", 0, 1, 0);
        set_test(4, "side_zoom_fit", 1, 2, 0);
        set_test(5, "stack_zoom_out", 2, 1, 2);
        set_test(6, "blank", 3, 0, 0);
        set_test(7, "single_zoom_clamp", 0, 3, 0);
        // Zoom in alone would fit here, so zoom out has to win
        set_test(8, "single_zoom_out_clamp", 0, 1, 3);
        seed      = 90;
        frame     = -1;
        col       = 0;
        row       = 0;
        line_seen = 1'b0;
        prev_hs   = 1'b1;
        prev_vs   = 1'b1;
        apply_settings(0);
        wait (frame == NUM_TESTS);
        $display("Regression passed");
        $finish;
    end

    always @(negedge vga_clk) begin : monitor
        logic             hs_fall;
        logic             vs_fall;
        logic [PIX_W-1:0] exp_rgb;
        int               sx;
        int               sy;
        if (!sys_rst_n) begin
            assert (vga_hsync === 1'b1 && vga_vsync === 1'b1 && vga_rgb === '0)
            else stop_on_error("Outputs were not idle while reset was held");
        end else if (frame < NUM_TESTS) begin
            hs_fall = prev_hs && !vga_hsync;
            vs_fall = prev_vs && !vga_vsync;
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
            assert (!vs_fall || hs_fall)
            else stop_on_error("Vertical sync fell away from the start of a line");
            if (hs_fall) begin
                if (line_seen) begin
                    assert (col == H_TOTAL - 1) else stop_on_error($sformatf(
                        "ERR line_length expected %0d actual %0d", H_TOTAL, col + 1));
                    assert (hs_low == H_SYNC) else stop_on_error($sformatf(
                        "ERR hsync_width expected %0d actual %0d", H_SYNC, hs_low));
                end
                line_seen = 1'b1;
                col       = 0;
                hs_low    = 0;
                row++;
            end else begin
                col++;
            end
            if (vs_fall) begin
                if (frame >= 0) begin
                    assert (frame_cyc == FRAME_CYC) else stop_on_error($sformatf(
                        "ERR frame_length expected %0d actual %0d", FRAME_CYC, frame_cyc));
                    assert (vs_low == V_SYNC * H_TOTAL) else stop_on_error($sformatf(
                        "ERR vsync_width expected %0d actual %0d", V_SYNC * H_TOTAL, vs_low));
                    if (log_x.size() > 0)
                        $display("%s: %0d logged positions in a copy, first at image (%0d,%0d)",
                                 t_name[frame], log_x.size(), log_x[0], log_y[0]);
                    else
                        $display("%s: no logged position fell in a copy", t_name[frame]);
                end
                row       = 0;
                frame_cyc = 0;
                vs_low    = 0;
                frame++;
                log_x.delete();
                log_y.delete();
                if (frame < NUM_TESTS) pick_positions();
                // Takes effect at the next frame start
                if (frame + 1 < NUM_TESTS && frame + 1 != MID_TEST) apply_settings(frame + 1);
            end
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            frame_cyc++;
            if (frame >= 0 && frame < NUM_TESTS) begin
                exp_rgb = expected_pixel(col, row, frame);
                assert (vga_rgb === exp_rgb) else stop_on_error($sformatf(
                    "ERR %s expected %h actual %h at column %0d line %0d",
                    t_name[frame], exp_rgb, vga_rgb, col, row));
                if (col >= H_ACT_START && col < H_ACT_START + H_ACTIVE &&
                    row >= V_ACT_START && row < V_ACT_START + V_ACTIVE &&
                    pick.exists((row - V_ACT_START) * H_ACTIVE + col - H_ACT_START) &&
                    map_position(col, row, t_mode[frame], t_zin[frame], t_zout[frame],
                                 sx, sy)) begin
                    log_x.push_back(sx);
                    log_y.push_back(sy);
                end
                // Mid-frame change must leave the rest of this frame alone
                if (frame == MID_TEST - 1 && row == MID_LINE && col == 0)
                    apply_settings(MID_TEST);
            end
        end
    end

    always @(negedge vga_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- vga_display_top.sv
`timescale 1ns/1ps

module vga_display_top #(
    parameter int IMG_WIDTH  = 200,
    parameter int IMG_HEIGHT = 200
) (
    input  logic                      vga_clk,
    input  logic                      sys_rst_n,
    input  logic [1:0]                display_mode,
    input  logic [1:0]                zoom_in_level,
    input  logic [1:0]                zoom_out_level,
    output logic                      vga_hsync,
    output logic                      vga_vsync,
    output logic [vga_pkg::PIX_W-1:0] vga_rgb
);
    import vga_pkg::*;

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic               hsync_raw;
    logic               vsync_raw;
    logic               in_image;
    logic [7:0]         img_x;
    logic [7:0]         img_y;
    logic [ADDR_W-1:0]  addr;
    logic [PIX_W-1:0]   q;

    vga_timing u_timing (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    display_window #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_window (
        .vga_clk        (vga_clk),
        .sys_rst_n      (sys_rst_n),
        .h_cnt          (h_cnt),
        .v_cnt          (v_cnt),
        .display_mode   (display_mode),
        .zoom_in_level  (zoom_in_level),
        .zoom_out_level (zoom_out_level),
        .in_image       (in_image),
        .img_x          (img_x),
        .img_y          (img_y)
    );

    pixel_fetch #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_fetch (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .in_image  (in_image),
        .img_x     (img_x),
        .img_y     (img_y),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .q         (q),
        .addr      (addr),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_rgb   (vga_rgb)
    );

    image_rom #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_rom (
        .vga_clk (vga_clk),
        .addr    (addr),
        .q       (q)
    );

endmodule

//--- vga_pkg.sv
package vga_pkg;

    // 800x600 at 60 Hz with a 40 MHz pixel clock
    // Sync pulse comes first in each line and frame, then back porch, active, front porch

    // Horizontal timing in pixel clocks
    localparam int H_TOTAL     = 1056;
    localparam int H_SYNC      = 128;
    localparam int H_ACT_START = 216;
    localparam int H_ACTIVE    = 800;

    // Vertical timing in lines
    localparam int V_TOTAL     = 628;
    localparam int V_SYNC      = 4;
    localparam int V_ACT_START = 27;
    localparam int V_ACTIVE    = 600;

    // Counter widths
    localparam int H_CNT_W = 11;
    localparam int V_CNT_W = 10;

    // Pixel and ROM address widths
    localparam int PIX_W  = 8;
    localparam int ADDR_W = 16;

    // Layout mode codes; code 3 blanks the screen
    localparam logic [1:0] MODE_SINGLE = 2'd0;
    localparam logic [1:0] MODE_SIDE   = 2'd1;
    localparam logic [1:0] MODE_STACK  = 2'd2;

    // Test pattern byte for a ROM address
    // Low address byte plus high address byte, wrapping at 256
    function automatic logic [PIX_W-1:0] test_pixel(input logic [ADDR_W-1:0] a);
        logic [PIX_W-1:0] lo;
        logic [PIX_W-1:0] hi;
        lo = a[PIX_W-1:0];
        hi = a[ADDR_W-1:PIX_W];
        return PIX_W'(lo + hi);
    endfunction

endpackage

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic                        vga_clk,
    input  logic                        sys_rst_n,
    output logic [vga_pkg::H_CNT_W-1:0] h_cnt,
    output logic [vga_pkg::V_CNT_W-1:0] v_cnt,
    output logic                        hsync_raw,
    output logic                        vsync_raw
);
    import vga_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = (h_cnt == H_CNT_W'(H_TOTAL - 1));
    assign frame_end = (v_cnt == V_CNT_W'(V_TOTAL - 1));

    // Column counter, runs every cycle
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            h_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + H_CNT_W'(1);
        end
    end

    // Line counter, steps on the last column of each line
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            v_cnt <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + V_CNT_W'(1);
            end
        end
    end

    // Syncs are low during the first columns / lines
    assign hsync_raw = (h_cnt >= H_CNT_W'(H_SYNC));
    assign vsync_raw = (v_cnt >= V_CNT_W'(V_SYNC));

endmodule
